// File: rtl/io_bus_pkg.sv
package io_bus_pkg;

	////////////////////////////////////////
	// Eight-bit port devices
	////////////////////////////////////////

	// Device codes, also the bit index into the toggle vectors
	typedef enum logic [2:0]
	{
		IO_NONE,
		IO_SPI,
		IO_PIT,
		IO_PIC,
		IO_VGA,
		IO_DBG,
		IO_PS2,
		IO_COM1
	} io_dev_t;

	typedef logic [7:0] io_byte_t;

	// Ten bits cover every mapped port up to 3FF
	typedef logic [9:0] io_addr_t;

	// One bit per device code
	typedef logic [7:0] io_dev_vec_t;

	// One read byte per device code
	typedef io_byte_t [7:0] io_dev_bytes_t;

	// Current byte request towards the devices
	typedef struct packed
	{
		io_addr_t port;
		io_byte_t data;
		io_dev_t  dev;
	} io_req_t;

endpackage

// File: rtl/pc_bus_pkg.sv
package pc_bus_pkg;

	import io_bus_pkg::*;

	////////////////////////////////////////
	// 80286 bus
	////////////////////////////////////////

	typedef logic [23:0] cpu_addr_t;
	typedef logic [15:0] cpu_data_t;

	// Low address bits during an I/O cycle
	typedef logic [11:0] io_port_t;

	typedef enum logic [2:0]
	{
		CYC_IDLE,
		CYC_MEM_READ,
		CYC_MEM_WRITE,
		CYC_IO_READ,
		CYC_IO_WRITE,
		CYC_INTA
	} bus_cycle_t;

	// Decoded bus cycle, held until the next address phase
	typedef struct packed
	{
		bus_cycle_t cycle;
		io_dev_t    dev;
		io_port_t   port;
		logic       bhe_n;
		cpu_data_t  wdata;
	} bus_cmd_t;

	// Unmapped and memory reads
	localparam cpu_data_t DATA_ALL_ONES = 16'hFFFF;

	////////////////////////////////////////
	// I/O port map
	////////////////////////////////////////

	function automatic io_dev_t io_port_map(io_port_t port, logic rd);
		io_dev_t dev;
		dev = IO_NONE;
		if (port >= 12'h0B0 && port <= 12'h0B3)
			dev = IO_SPI;
		else if (port >= 12'h040 && port <= 12'h043)
			dev = IO_PIT;
		else if (port >= 12'h020 && port <= 12'h021)
			dev = IO_PIC;
		else if ((port >= 12'h3A0 && port <= 12'h3DF) || port == 12'h0BE)
			dev = IO_VGA;
		// Debug UART has no read side
		else if (port == 12'h0BC && !rd)
			dev = IO_DBG;
		else if (port >= 12'h060 && port <= 12'h067)
			dev = IO_PS2;
		else if (port >= 12'h3F8 && port <= 12'h3FF)
			dev = IO_COM1;
		return dev;
	endfunction

endpackage

// File: rtl/cpu_reset_timer.sv
`timescale 1ns/100ps

module cpu_reset_timer #(
	parameter int RESET_HOLD_CYCLES = 64
)(
	input  logic clk,
	input  logic reset_n,
	output logic cpu_reset
);

	// One spare count so a hold of one cycle still has a counter bit
	localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			hold_cnt  <= '0;
			cpu_reset <= 1'b1;
		end
		else if (cpu_reset)
		begin
			// Release on the last held cycle, then stay low
			if (hold_cnt == CNT_W'(RESET_HOLD_CYCLES - 1))
				cpu_reset <= 1'b0;
			else
				hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule

// File: rtl/bus_cycle_decoder.sv
`timescale 1ns/100ps

module bus_cycle_decoder import pc_bus_pkg::*, io_bus_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  cpu_addr_t cpu_a,
	input  logic      cpu_bhe_n,
	input  logic      cpu_s0_n,
	input  logic      cpu_s1_n,
	input  logic      cpu_mio,
	input  logic      cpu_inta_n,
	input  cpu_data_t cpu_wdata,
	output bus_cmd_t  cmd,
	output logic      start
);

	// Status lines of the previous edge
	logic [1:0] prev_status;

	logic       addr_phase;
	logic       data_phase;
	bus_cycle_t cycle_dec;
	io_dev_t    dev_dec;

	////////////////////////////////////////
	// Phase detection
	////////////////////////////////////////

	// Any status line low marks the address phase
	assign addr_phase = !cpu_s1_n || !cpu_s0_n;

	// Both high again right after an address phase
	assign data_phase = !addr_phase && (prev_status != 2'b11);

	////////////////////////////////////////
	// Cycle type and target device
	////////////////////////////////////////

	always_comb
	begin
		casez ({cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n})
			4'b?101: cycle_dec = CYC_MEM_READ;
			4'b?110: cycle_dec = CYC_MEM_WRITE;
			4'b?001: cycle_dec = CYC_IO_READ;
			4'b?010: cycle_dec = CYC_IO_WRITE;
			4'b0000: cycle_dec = CYC_INTA;
			// Halt and passive status
			default: cycle_dec = CYC_IDLE;
		endcase
	end

	// Only I/O cycles reach a port device
	always_comb
	begin
		if (cycle_dec == CYC_IO_READ || cycle_dec == CYC_IO_WRITE)
			dev_dec = io_port_map(cpu_a[11:0], cycle_dec == CYC_IO_READ);
		else
			dev_dec = IO_NONE;
	end

	////////////////////////////////////////
	// Command register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			prev_status <= 2'b11;
			cmd         <= '0;
			start       <= 1'b0;
		end
		else
		begin
			prev_status <= {cpu_s1_n, cpu_s0_n};
			start       <= 1'b0;

			if (addr_phase)
			begin
				cmd.cycle <= cycle_dec;
				cmd.dev   <= dev_dec;
				cmd.port  <= cpu_a[11:0];
				cmd.bhe_n <= cpu_bhe_n;
			end
			else if (data_phase)
			begin
				// Write data is valid on this edge
				cmd.wdata <= cpu_wdata;
				start     <= cmd.cycle != CYC_IDLE;
			end
			else if (start)
				// Handed over, the bridge keeps its own copy of the type
				cmd.cycle <= CYC_IDLE;
		end
	end

endmodule

// File: rtl/io_byte_bridge.sv
`timescale 1ns/100ps

module io_byte_bridge import pc_bus_pkg::*, io_bus_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  bus_cmd_t  cmd,
	input  logic      start,
	input  io_byte_t  irq_vector,
	input  logic      io_idle,
	input  io_byte_t  io_byte,
	output io_req_t   req,
	output logic      rd_strobe,
	output logic      wr_strobe,
	output cpu_data_t cpu_rdata,
	output logic      cpu_ready
);

	typedef enum logic [1:0]
	{
		BR_IDLE,
		BR_WAIT,
		BR_RUN
	} br_state_t;

	br_state_t  state;
	bus_cycle_t cyc;
	logic       phase0;
	logic       phase1;
	cpu_data_t  result;
	cpu_data_t  word_next;
	logic       cmd_io;
	logic       first_issue;
	logic       second_issue;
	logic       phase_done;
	logic       last_phase;

	assign cmd_io = cmd.cycle == CYC_IO_READ || cmd.cycle == CYC_IO_WRITE;

	// Unmapped ports complete each phase on their own in one cycle
	assign phase_done = cmd.dev == IO_NONE || io_idle;

	////////////////////////////////////////
	// Byte requests
	////////////////////////////////////////

	// First byte goes out with start, even port first
	assign first_issue = state == BR_WAIT && start && cmd_io && cmd.dev != IO_NONE
		&& (!cmd.port[0] || !cmd.bhe_n);

	// High byte once the low byte is acknowledged
	assign second_issue = state == BR_RUN && phase0 && phase1 && phase_done
		&& cmd.dev != IO_NONE;

	assign rd_strobe = first_issue ? cmd.cycle == CYC_IO_READ :
		second_issue && cyc == CYC_IO_READ;
	assign wr_strobe = first_issue ? cmd.cycle == CYC_IO_WRITE :
		second_issue && cyc == CYC_IO_WRITE;

	// Outside start only the odd phase is ever issued
	assign req.port = {cmd.port[9:1], start ? cmd.port[0] : 1'b1};
	assign req.data = (start && !cmd.port[0]) ? cmd.wdata[7:0] : cmd.wdata[15:8];
	assign req.dev  = cmd.dev;

	////////////////////////////////////////
	// Read word assembly
	////////////////////////////////////////

	always_comb
	begin
		word_next = result;
		if (state == BR_RUN && phase_done && cyc == CYC_IO_READ && cmd.dev != IO_NONE)
		begin
			if (phase0)
				word_next[7:0] = io_byte;
			else if (phase1)
				word_next[15:8] = io_byte;
		end
	end

	// Nothing left after the current edge
	assign last_phase = state == BR_RUN &&
		(phase0 ? (phase_done && !phase1) : (!phase1 || phase_done));

	always_ff @(posedge clk)
	begin
		// Unrequested bytes read as FF
		if (state == BR_WAIT && start)
			result <= DATA_ALL_ONES;
		else if (state == BR_RUN)
			result <= word_next;

		if (last_phase)
		begin
			case (cyc)
				CYC_IO_READ: cpu_rdata <= word_next;
				CYC_INTA:    cpu_rdata <= {8'h00, irq_vector};
				default:     cpu_rdata <= DATA_ALL_ONES;
			endcase
		end
	end

	////////////////////////////////////////
	// Cycle FSM and ready
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state     <= BR_IDLE;
			cyc       <= CYC_IDLE;
			phase0    <= 1'b0;
			phase1    <= 1'b0;
			cpu_ready <= 1'b1;
		end
		else
		begin
			case (state)
				BR_IDLE:
				begin
					// Address phase seen, hold the CPU
					if (cmd.cycle != CYC_IDLE)
					begin
						cpu_ready <= 1'b0;
						state     <= BR_WAIT;
					end
				end
				BR_WAIT:
				begin
					if (start)
					begin
						cyc    <= cmd.cycle;
						phase0 <= cmd_io && !cmd.port[0];
						phase1 <= cmd_io && !cmd.bhe_n;
						state  <= BR_RUN;
					end
				end
				default:
				begin
					if (phase0 && phase_done)
						phase0 <= 1'b0;
					else if (!phase0 && phase1 && phase_done)
						phase1 <= 1'b0;
					if (last_phase)
					begin
						cpu_ready <= 1'b1;
						state     <= BR_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: rtl/io_request_port.sv
`timescale 1ns/100ps

module io_request_port import io_bus_pkg::*;
(
	input  logic          clk,
	input  logic          reset_n,
	input  io_req_t       req,
	input  logic          rd_strobe,
	input  logic          wr_strobe,
	input  io_dev_vec_t   io_rd_ack,
	input  io_dev_vec_t   io_wr_ack,
	input  io_dev_bytes_t io_rdata,
	output io_req_t       io_req,
	output io_dev_vec_t   io_rd_req,
	output io_dev_vec_t   io_wr_req,
	output logic          io_idle,
	output io_byte_t      io_byte
);

	////////////////////////////////////////
	// Request toggles
	////////////////////////////////////////

	// A flip of one bit is one request to that device
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			io_rd_req <= '0;
			io_wr_req <= '0;
		end
		else
		begin
			if (rd_strobe)
				io_rd_req[req.dev] <= ~io_rd_req[req.dev];
			if (wr_strobe)
				io_wr_req[req.dev] <= ~io_wr_req[req.dev];
		end
	end

	// Port, byte and device held for the whole request
	always_ff @(posedge clk)
	begin
		if (rd_strobe || wr_strobe)
			io_req <= req;
	end

	////////////////////////////////////////
	// Completion and read data
	////////////////////////////////////////

	// Every device has caught up with its request
	assign io_idle = (io_rd_req == io_rd_ack) && (io_wr_req == io_wr_ack);

	// Byte of the device being addressed
	assign io_byte = io_rdata[io_req.dev];

endmodule

// File: rtl/pc_bus_top.sv
`timescale 1ns/100ps

module pc_bus_top import pc_bus_pkg::*, io_bus_pkg::*; #(
	parameter int RESET_HOLD_CYCLES = 64
)(
	input  logic          clk,
	input  logic          reset_n,

	// CPU side
	input  cpu_addr_t     cpu_a,
	input  logic          cpu_bhe_n,
	input  logic          cpu_s0_n,
	input  logic          cpu_s1_n,
	input  logic          cpu_mio,
	input  logic          cpu_inta_n,
	input  cpu_data_t     cpu_wdata,
	input  io_byte_t      irq_vector,
	output cpu_data_t     cpu_rdata,
	output logic          cpu_ready,
	output logic          cpu_reset,

	// Port devices
	output io_req_t       io_req,
	output io_dev_vec_t   io_rd_req,
	output io_dev_vec_t   io_wr_req,
	input  io_dev_vec_t   io_rd_ack,
	input  io_dev_vec_t   io_wr_ack,
	input  io_dev_bytes_t io_rdata
);

	bus_cmd_t cmd;
	logic     start;
	io_req_t  req;
	logic     rd_strobe;
	logic     wr_strobe;
	logic     io_idle;
	io_byte_t io_byte;

	cpu_reset_timer #(
		.RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
	) cpu_reset_timer_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.cpu_reset (cpu_reset)
	);

	// Bus sampling and decode
	bus_cycle_decoder bus_cycle_decoder_inst (
		.clk        (clk),
		.reset_n    (reset_n),
		.cpu_a      (cpu_a),
		.cpu_bhe_n  (cpu_bhe_n),
		.cpu_s0_n   (cpu_s0_n),
		.cpu_s1_n   (cpu_s1_n),
		.cpu_mio    (cpu_mio),
		.cpu_inta_n (cpu_inta_n),
		.cpu_wdata  (cpu_wdata),
		.cmd        (cmd),
		.start      (start)
	);

	// 16 to 8 bit bridge
	io_byte_bridge io_byte_bridge_inst (
		.clk        (clk),
		.reset_n    (reset_n),
		.cmd        (cmd),
		.start      (start),
		.irq_vector (irq_vector),
		.io_idle    (io_idle),
		.io_byte    (io_byte),
		.req        (req),
		.rd_strobe  (rd_strobe),
		.wr_strobe  (wr_strobe),
		.cpu_rdata  (cpu_rdata),
		.cpu_ready  (cpu_ready)
	);

	io_request_port io_request_port_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.req       (req),
		.rd_strobe (rd_strobe),
		.wr_strobe (wr_strobe),
		.io_rd_ack (io_rd_ack),
		.io_wr_ack (io_wr_ack),
		.io_rdata  (io_rdata),
		.io_req    (io_req),
		.io_rd_req (io_rd_req),
		.io_wr_req (io_wr_req),
		.io_idle   (io_idle),
		.io_byte   (io_byte)
	);

endmodule

// File: sim/pc_bus_chk.sv
`timescale 1ns/100ps

module pc_bus_chk import io_bus_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  io_req_t     io_req,
	input  io_dev_vec_t io_rd_req,
	input  io_dev_vec_t io_wr_req,
	input  io_dev_vec_t io_rd_ack,
	input  io_dev_vec_t io_wr_ack,
	input  logic        cpu_ready
);

	// Some device has not caught up with its request
	logic pending;

	// Failed assertions so far
	int fail_count;

	assign pending = (io_rd_req != io_rd_ack) || (io_wr_req != io_wr_ack);

	////////////////////////////////////////
	// Toggle port rules
	////////////////////////////////////////

	// One request per edge over all devices, read and write
	single_toggle: assert property (@(posedge clk) disable iff (!reset_n)
		$onehot0({io_rd_req ^ $past(io_rd_req), io_wr_req ^ $past(io_wr_req)}))
	else
	begin
		fail_count++;
		$error("more than one request toggle changed on one edge");
	end

	// Port, byte and device frozen until the acknowledge
	req_stable: assert property (@(posedge clk) disable iff (!reset_n)
		pending |=> $stable(io_req))
	else
	begin
		fail_count++;
		$error("io_req changed while a request was outstanding");
	end

	// CPU held while a device is busy
	ready_held: assert property (@(posedge clk) disable iff (!reset_n)
		pending |-> !cpu_ready)
	else
	begin
		fail_count++;
		$error("cpu_ready high while a request was outstanding");
	end

endmodule

// File: sim/pc_bus_tb.sv
`timescale 1ns/100ps

module pc_bus_tb import pc_bus_pkg::*, io_bus_pkg::*;
();

	localparam int CLK_PERIOD      = 20;
	localparam int DRIVE_DLY       = 1;
	localparam int HOLD_CYCLES     = 20;
	localparam int READY_LIMIT     = 50;
	// Reset test plus directed cycles, then the random run
	localparam int NUM_DIRECTED    = 50;
	localparam int NUM_RANDOM      = 300;
	localparam int NUM_TESTS       = NUM_DIRECTED + NUM_RANDOM;
	localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS;

	typedef enum logic [2:0]
	{
		OP_MEM_RD,
		OP_MEM_WR,
		OP_IO_RD,
		OP_IO_WR,
		OP_INTA
	} cpu_op_t;

	// One byte request as the devices see it
	typedef struct packed
	{
		logic     rd;
		io_dev_t  dev;
		io_dev_t  req_dev;
		io_addr_t port;
		io_byte_t data;
	} seen_req_t;

	logic          clk;
	logic          reset_n;
	cpu_addr_t     cpu_a;
	logic          cpu_bhe_n;
	logic          cpu_s0_n;
	logic          cpu_s1_n;
	logic          cpu_mio;
	logic          cpu_inta_n;
	cpu_data_t     cpu_wdata;
	io_byte_t      irq_vector;
	cpu_data_t     cpu_rdata;
	logic          cpu_ready;
	logic          cpu_reset;
	io_req_t       io_req;
	io_dev_vec_t   io_rd_req;
	io_dev_vec_t   io_wr_req;
	io_dev_vec_t   io_rd_ack;
	io_dev_vec_t   io_wr_ack;
	io_dev_bytes_t io_rdata;

	seen_req_t     seen_q[$];
	seen_req_t     want_q[$];
	io_dev_vec_t   last_rd;
	io_dev_vec_t   last_wr;
	int            ack_wait [8];
	int            checks;
	int            value_errs;
	int            other_errs;
	int            assert_errs;

	pc_bus_top #(
		.RESET_HOLD_CYCLES(HOLD_CYCLES)
	) pc_bus_top_inst (
		.clk        (clk),
		.reset_n    (reset_n),
		.cpu_a      (cpu_a),
		.cpu_bhe_n  (cpu_bhe_n),
		.cpu_s0_n   (cpu_s0_n),
		.cpu_s1_n   (cpu_s1_n),
		.cpu_mio    (cpu_mio),
		.cpu_inta_n (cpu_inta_n),
		.cpu_wdata  (cpu_wdata),
		.irq_vector (irq_vector),
		.cpu_rdata  (cpu_rdata),
		.cpu_ready  (cpu_ready),
		.cpu_reset  (cpu_reset),
		.io_req     (io_req),
		.io_rd_req  (io_rd_req),
		.io_wr_req  (io_wr_req),
		.io_rd_ack  (io_rd_ack),
		.io_wr_ack  (io_wr_ack),
		.io_rdata   (io_rdata)
	);

	bind pc_bus_top pc_bus_chk pc_bus_chk_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.io_req    (io_req),
		.io_rd_req (io_rd_req),
		.io_wr_req (io_wr_req),
		.io_rd_ack (io_rd_ack),
		.io_wr_ack (io_wr_ack),
		.cpu_ready (cpu_ready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Port devices
	////////////////////////////////////////

	// Each device answers after 1 to 4 cycles with port low byte XOR its code
	always @(posedge clk)
	begin
		#DRIVE_DLY;
		for (int d = 1; d < 8; d++)
		begin
			if (io_rd_req[d] != io_rd_ack[d] || io_wr_req[d] != io_wr_ack[d])
			begin
				if (ack_wait[d] == 0)
					ack_wait[d] = $urandom_range(1, 4);
				ack_wait[d]--;
				if (ack_wait[d] == 0)
				begin
					io_rdata[d]  = io_req.port[7:0] ^ 8'(d);
					io_rd_ack[d] = io_rd_req[d];
					io_wr_ack[d] = io_wr_req[d];
				end
			end
		end
	end

	// Record every toggle with the request it carried
	always @(negedge clk)
	begin
		seen_req_t r;
		if (reset_n)
		begin
			for (int d = 0; d < 8; d++)
			begin
				if (io_rd_req[d] != last_rd[d])
				begin
					r         = make_req(1'b1, io_dev_t'(d), io_req.port, io_req.data);
					r.req_dev = io_req.dev;
					seen_q.push_back(r);
				end
				if (io_wr_req[d] != last_wr[d])
				begin
					r         = make_req(1'b0, io_dev_t'(d), io_req.port, io_req.data);
					r.req_dev = io_req.dev;
					seen_q.push_back(r);
				end
			end
		end
		last_rd = io_rd_req;
		last_wr = io_wr_req;
	end

	////////////////////////////////////////
	// Model
	////////////////////////////////////////

	function automatic seen_req_t make_req(logic rd, io_dev_t dev, io_addr_t port,
		io_byte_t data);
		seen_req_t r;
		r.rd      = rd;
		r.dev     = dev;
		r.req_dev = dev;
		r.port    = port;
		r.data    = data;
		return r;
	endfunction

	// Port map, reads of the debug port go nowhere
	function automatic io_dev_t expect_device(io_port_t port, logic rd);
		case (port) inside
			[12'h0B0:12'h0B3]:        return IO_SPI;
			[12'h040:12'h043]:        return IO_PIT;
			[12'h020:12'h021]:        return IO_PIC;
			[12'h3A0:12'h3DF], 12'h0BE: return IO_VGA;
			12'h0BC:                  return rd ? IO_NONE : IO_DBG;
			[12'h060:12'h067]:        return IO_PS2;
			[12'h3F8:12'h3FF]:        return IO_COM1;
			default:                  return IO_NONE;
		endcase
	endfunction

	// Some port inside the range of a device
	function automatic io_port_t pick_port(io_dev_t dev);
		case (dev)
			IO_SPI:  return 12'h0B0 + 12'($urandom_range(0, 3));
			IO_PIT:  return 12'h040 + 12'($urandom_range(0, 3));
			IO_PIC:  return 12'h020 + 12'($urandom_range(0, 1));
			IO_VGA:  return ($urandom_range(0, 3) == 0) ? 12'h0BE :
				12'h3A0 + 12'($urandom_range(0, 63));
			IO_DBG:  return 12'h0BC;
			IO_PS2:  return 12'h060 + 12'($urandom_range(0, 7));
			IO_COM1: return 12'h3F8 + 12'($urandom_range(0, 7));
			// Low range or ports above 3FF that alias mapped ones
			default: return $urandom_range(0, 1) ? 12'h100 + 12'($urandom_range(0, 255)) :
				12'($urandom_range(12'h400, 12'hFFF));
		endcase
	endfunction

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
		checks++;
		assert (got === want)
		else
		begin
			value_errs++;
			$display("error %0t %s got %0h expected %0h", $time, name, got, want);
		end
	endtask

	// Requests seen since the last cycle against the model, in order
	task automatic compare_requests();
		checks++;
		assert (seen_q.size() == want_q.size())
		else
		begin
			other_errs++;
			$display("error %0t devices saw %0d byte requests where %0d were expected",
				$time, seen_q.size(), want_q.size());
		end
		for (int i = 0; i < want_q.size() && i < seen_q.size(); i++)
		begin
			compare_value("request direction", 32'(seen_q[i].rd), 32'(want_q[i].rd));
			compare_value("request device", 32'(seen_q[i].dev), 32'(want_q[i].dev));
			compare_value("io_req.dev", 32'(seen_q[i].req_dev), 32'(want_q[i].dev));
			compare_value("io_req.port", 32'(seen_q[i].port), 32'(want_q[i].port));
			if (!want_q[i].rd)
				compare_value("io_req.data", 32'(seen_q[i].data), 32'(want_q[i].data));
		end
		seen_q.delete();
	endtask

	////////////////////////////////////////
	// CPU driver
	////////////////////////////////////////

	// Called a little after a rising edge, returns the same way
	task automatic run_cycle(cpu_op_t op, cpu_addr_t addr, logic bhe_n, cpu_data_t wdata);
		io_port_t  port;
		io_addr_t  odd_port;
		io_dev_t   dev;
		io_byte_t  vec;
		logic      rd;
		logic      ph0;
		logic      ph1;
		cpu_data_t want_data;
		int        waited;
		port      = addr[11:0];
		rd        = op == OP_IO_RD;
		dev       = IO_NONE;
		ph0       = 1'b0;
		ph1       = 1'b0;
		vec       = 8'($urandom);
		want_data = 16'hFFFF;
		want_q.delete();
		if (op == OP_IO_RD || op == OP_IO_WR)
		begin
			dev = expect_device(port, rd);
			ph0 = !port[0];
			ph1 = !bhe_n;
		end
		// Even byte first, high byte at the odd port
		if (dev != IO_NONE && ph0)
		begin
			want_q.push_back(make_req(rd, dev, port[9:0], wdata[7:0]));
			want_data[7:0] = port[7:0] ^ 8'(dev);
		end
		if (dev != IO_NONE && ph1)
		begin
			odd_port = {port[9:1], 1'b1};
			want_q.push_back(make_req(rd, dev, odd_port, wdata[15:8]));
			want_data[15:8] = odd_port[7:0] ^ 8'(dev);
		end
		if (op == OP_INTA)
			want_data = {8'h00, vec};

		// Address phase
		cpu_a      = addr;
		cpu_bhe_n  = bhe_n;
		cpu_wdata  = wdata;
		irq_vector = vec;
		case (op)
			OP_MEM_RD: {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b1101;
			OP_MEM_WR: {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b1110;
			OP_IO_RD:  {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b1001;
			OP_IO_WR:  {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b1010;
			default:   {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b0000;
		endcase
		@(posedge clk);
		#DRIVE_DLY;
		// Data phase
		{cpu_inta_n, cpu_s1_n, cpu_s0_n} = 3'b111;
		@(posedge clk);
		#DRIVE_DLY;
		compare_value("cpu_ready", 32'(cpu_ready), 32'd0);

		waited = 0;
		while (!cpu_ready && waited < READY_LIMIT)
		begin
			@(posedge clk);
			#DRIVE_DLY;
			waited++;
		end
		checks++;
		assert (cpu_ready)
		else
		begin
			other_errs++;
			$display("error %0t cpu_ready stayed low %0d cycles after the data phase",
				$time, READY_LIMIT);
		end

		if (op == OP_IO_RD || op == OP_MEM_RD || op == OP_INTA)
			compare_value("cpu_rdata", 32'(cpu_rdata), 32'(want_data));
		compare_requests();
		// Without devices each phase takes one cycle, at least two edges
		if (want_q.size() == 0)
			compare_value("cpu_ready latency", waited, (ph0 && ph1) ? 3 : 2);
	endtask

	// Width 0 even byte, 1 odd byte, 2 word
	task automatic run_io(cpu_op_t op, io_dev_t dev, int width);
		io_port_t port;
		port    = pick_port(dev);
		port[0] = width == 1;
		run_cycle(op, {12'h000, port}, width == 0, 16'($urandom));
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		void'($urandom(32'hd487));
		clk        = 1'b0;
		reset_n    = 1'b0;
		cpu_a      = '0;
		cpu_bhe_n  = 1'b1;
		cpu_s0_n   = 1'b1;
		cpu_s1_n   = 1'b1;
		cpu_mio    = 1'b1;
		cpu_inta_n = 1'b1;
		cpu_wdata  = '0;
		irq_vector = '0;
		io_rd_ack  = '0;
		io_wr_ack  = '0;
		io_rdata   = '0;
		checks     = 0;
		value_errs = 0;
		other_errs = 0;

		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		reset_n = 1'b1;
		compare_value("cpu_ready", 32'(cpu_ready), 32'd1);
		compare_value("io_rd_req", 32'(io_rd_req), 32'd0);
		compare_value("io_wr_req", 32'(io_wr_req), 32'd0);
		compare_value("cpu_reset", 32'(cpu_reset), 32'd1);
		// Falls on the last edge of the hold
		for (int i = 1; i <= HOLD_CYCLES; i++)
		begin
			@(posedge clk);
			#DRIVE_DLY;
			compare_value("cpu_reset", 32'(cpu_reset), 32'(i < HOLD_CYCLES));
		end

		// Writes to every device in every width
		for (int d = 1; d < 8; d++)
			for (int w = 0; w < 3; w++)
				run_io(OP_IO_WR, io_dev_t'(d), w);
		// Reads, the debug port is write only
		for (int d = 1; d < 8; d++)
			if (io_dev_t'(d) != IO_DBG)
				for (int w = 0; w < 3; w++)
					run_io(OP_IO_RD, io_dev_t'(d), w);
		for (int w = 0; w < 3; w++)
			run_io(OP_IO_RD, IO_NONE, w);
		run_io(OP_IO_RD, IO_DBG, 0);
		for (int i = 0; i < 2; i++)
		begin
			run_cycle(OP_MEM_RD, 24'($urandom), 1'($urandom), 16'($urandom));
			run_cycle(OP_MEM_WR, 24'($urandom), 1'($urandom), 16'($urandom));
			run_cycle(OP_INTA, '0, 1'b1, '0);
		end

		// Mixed run
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			cpu_op_t op;
			op = cpu_op_t'($urandom_range(0, 4));
			if (op == OP_IO_RD || op == OP_IO_WR)
				run_io(op, io_dev_t'($urandom_range(0, 7)), $urandom_range(0, 2));
			else
				run_cycle(op, 24'($urandom), 1'($urandom), 16'($urandom));
		end

		compare_value("cpu_reset", 32'(cpu_reset), 32'd0);
		assert_errs = pc_bus_top_inst.pc_bus_chk_inst.fail_count;
		$display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
			checks, value_errs, other_errs, assert_errs);
		if (value_errs + other_errs + assert_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, the bus cycles did not finish within %0d clock cycles",
			WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verilog.f
rtl/io_bus_pkg.sv
rtl/pc_bus_pkg.sv
rtl/cpu_reset_timer.sv
rtl/bus_cycle_decoder.sv
rtl/io_byte_bridge.sv
rtl/io_request_port.sv
rtl/pc_bus_top.sv
sim/pc_bus_chk.sv
sim/pc_bus_tb.sv

// File: Makefile
# Verilator build and run of the bus bridge testbench

VERILATOR ?= verilator
TOP       ?= pc_bus_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
